//--- filelist.f
axil_pkg.sv
cl_shell_pkg.sv
axil_reg_slice.sv
cl_ctrl.sv
status_io.sv
profile_counter.sv
cl_top.sv
tb_clk_gen.sv
tb_cl_top.sv

//--- Bender.yml
package:
  name: cl_shell

sources:
  - files:
      - axil_pkg.sv
      - cl_shell_pkg.sv
      - axil_reg_slice.sv
      - cl_ctrl.sv
      - status_io.sv
      - profile_counter.sv
      - cl_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_cl_top.sv

//--- tb_cl_top.sv
// Shell register block testbench
`timescale 1ns/10ps

module tb_cl_top;
   import axil_pkg::*;
   import cl_shell_pkg::*;

   localparam int         CLK_PERIOD = 10;
   localparam int         SETTLE_NS  = 2;
   localparam int         HS_LIMIT   = 20;
   localparam int         NUM_TESTS  = 24;
   localparam axil_data_t ID0        = 32'hC0DE_0A11;
   localparam axil_data_t ID1        = 32'h5EED_1D01;
   localparam vled_t      LED_INIT   = 16'hBEEF;

   typedef enum logic [2:0] {OP_RD, OP_WR, OP_PORT, OP_DIP, OP_CYC, OP_STATCYC} op_e;

   typedef struct packed {
      op_e        op;
      axil_addr_t addr;
      axil_data_t wdata;
      axil_strb_t strb;
      axil_data_t exp_data;
      axil_resp_t exp_resp;
      logic [3:0] delay;
   } test_t;

   logic       clk_main_a0;
   logic       rst_main_n_sync;
   axil_req_t  s_axil_req;
   axil_rsp_t  s_axil_rsp;
   vdip_t      vdip;
   vled_t      vled_port;
   logic       print_stat_v;
   axil_data_t print_stat_tag;

   test_t      tests [NUM_TESTS];
   int         num_built = 0;
   int         err_cnt   = 0;
   int         fail_cnt  = 0;
   int         pulse_cnt = 0;
   axil_data_t pulse_tag = '0;

   tb_clk_gen #(.CLK_PERIOD(CLK_PERIOD)) u_tb_clk_gen (
      .clk_o   (clk_main_a0),
      .rst_n_o (rst_main_n_sync)
   );

   cl_top #(
      .CL_ID0      (ID0),
      .CL_ID1      (ID1),
      .LED_PATTERN (LED_INIT)
   ) u_cl_top (
      .clk_main_a0         (clk_main_a0),
      .rst_main_n_sync     (rst_main_n_sync),
      .s_axil_req_i        (s_axil_req),
      .s_axil_rsp_o        (s_axil_rsp),
      .sh_cl_status_vdip_i (vdip),
      .cl_sh_status_vled_o (vled_port),
      .print_stat_v_o      (print_stat_v),
      .print_stat_tag_o    (print_stat_tag)
   );

   // Count print-stat pulses on the falling edge
   always @(negedge clk_main_a0) begin
      if (print_stat_v === 1'b1) begin
         pulse_cnt = pulse_cnt + 1;
         pulse_tag = print_stat_tag;
      end
   end

   // ------------------------------
   // Reference helpers
   // ------------------------------
   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // Only strobes 0 and 1 reach the LED bytes
   function automatic vled_t merge_vled(input vled_t old, input axil_data_t data,
                                        input axil_strb_t strb);
      vled_t mask;
      mask = {{8{strb[1]}}, {8{strb[0]}}};
      return (old & ~mask) | (data[15:0] & mask);
   endfunction

   function automatic logic rsp_valid(input logic is_read);
      return is_read ? s_axil_rsp.r_valid : s_axil_rsp.b_valid;
   endfunction

   function automatic logic [33:0] rsp_payload(input logic is_read);
      return is_read ? {s_axil_rsp.r_resp, s_axil_rsp.r_data} : {s_axil_rsp.b_resp, 32'h0};
   endfunction

   // ------------------------------
   // Compare tasks
   // ------------------------------
   task automatic check_data(input axil_data_t got, input axil_data_t exp, input string what);
      if (got !== exp) begin
         $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_resp(input axil_resp_t got, input axil_resp_t exp, input string what);
      if (got !== exp) begin
         $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_vled(input vled_t got, input vled_t exp);
      if (got !== exp) begin
         $display("[ERROR] %0t: LED port is %h, expected %h", $time, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_stat(input int pulses, input int exp_pulses, input axil_data_t tag,
                             input axil_data_t exp_tag);
      if (pulses != exp_pulses) begin
         $display("[ERROR] %0t: %0d print-stat pulses, expected %0d", $time, pulses, exp_pulses);
         err_cnt++;
      end else if (exp_pulses > 0 && tag !== exp_tag) begin
         $display("[ERROR] %0t: print-stat tag is %h, expected %h", $time, tag, exp_tag);
         err_cnt++;
      end
   endtask

   task automatic check_cycle_order(input cycle_t lo, input cycle_t hi, input logic strict,
                                    input string what);
      if ($isunknown(hi) || hi < lo || (strict && hi == lo)) begin
         $display("[ERROR] %0t: %s is %0d, not above %0d", $time, what, hi, lo);
         err_cnt++;
      end
   endtask

   task automatic note_failure(input string msg);
      $display("%0t: %s", $time, msg);
      err_cnt++;
   endtask

   // ------------------------------
   // AXI-Lite driver
   // ------------------------------
   // Entered and left just after a falling edge
   task automatic take_response(input logic is_read, input int delay, output logic [33:0] pld);
      int n;
      n = 0;
      while (!rsp_valid(is_read) && n < HS_LIMIT) begin
         @(negedge clk_main_a0);
         #(SETTLE_NS);
         n++;
      end
      pld = rsp_payload(is_read);
      if (!rsp_valid(is_read)) begin
         note_failure(is_read ? "read response never arrived" : "write response never arrived");
      end else begin
         repeat (delay) begin
            @(negedge clk_main_a0);
            #(SETTLE_NS);
            if (!rsp_valid(is_read) || rsp_payload(is_read) !== pld) begin
               note_failure("response changed while ready was held low");
            end
         end
         @(negedge clk_main_a0);
         if (is_read)
            s_axil_req.r_ready = 1'b1;
         else
            s_axil_req.b_ready = 1'b1;
         @(negedge clk_main_a0);
         s_axil_req.r_ready = 1'b0;
         s_axil_req.b_ready = 1'b0;
      end
      #(SETTLE_NS);
   endtask

   task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                             input axil_strb_t strb, input int delay, output axil_resp_t resp);
      logic [33:0] pld;
      logic        aw_hs;
      logic        w_hs;
      int          n;
      @(negedge clk_main_a0);
      s_axil_req.aw_addr  = addr;
      s_axil_req.aw_valid = 1'b1;
      s_axil_req.w_data   = data;
      s_axil_req.w_strb   = strb;
      s_axil_req.w_valid  = 1'b1;
      n = 0;
      while ((s_axil_req.aw_valid || s_axil_req.w_valid) && n < HS_LIMIT) begin
         #(SETTLE_NS);
         // Ready seen here means a transfer on the coming rising edge
         aw_hs = s_axil_req.aw_valid && s_axil_rsp.aw_ready;
         w_hs  = s_axil_req.w_valid && s_axil_rsp.w_ready;
         @(negedge clk_main_a0);
         if (aw_hs) s_axil_req.aw_valid = 1'b0;
         if (w_hs) s_axil_req.w_valid = 1'b0;
         n++;
      end
      if (s_axil_req.aw_valid || s_axil_req.w_valid) begin
         note_failure("write address or data was never accepted");
         s_axil_req.aw_valid = 1'b0;
         s_axil_req.w_valid  = 1'b0;
      end
      #(SETTLE_NS);
      take_response(1'b0, delay, pld);
      resp = pld[33:32];
   endtask

   task automatic axil_read(input axil_addr_t addr, input int delay,
                            output axil_data_t data, output axil_resp_t resp);
      logic [33:0] pld;
      logic        ar_hs;
      int          n;
      @(negedge clk_main_a0);
      s_axil_req.ar_addr  = addr;
      s_axil_req.ar_valid = 1'b1;
      n = 0;
      while (s_axil_req.ar_valid && n < HS_LIMIT) begin
         #(SETTLE_NS);
         ar_hs = s_axil_rsp.ar_ready;
         @(negedge clk_main_a0);
         if (ar_hs) s_axil_req.ar_valid = 1'b0;
         n++;
      end
      if (s_axil_req.ar_valid) begin
         note_failure("read address was never accepted");
         s_axil_req.ar_valid = 1'b0;
      end
      #(SETTLE_NS);
      take_response(1'b1, delay, pld);
      resp = pld[33:32];
      data = pld[31:0];
   endtask

   // ------------------------------
   // Stimulus table
   // ------------------------------
   task automatic add_test(input op_e op, input axil_addr_t addr, input axil_data_t wdata,
                           input axil_strb_t strb, input axil_data_t exp_data,
                           input axil_resp_t exp_resp, input int delay);
      if (num_built < NUM_TESTS) begin
         tests[num_built] = {op, addr, wdata, strb, exp_data, exp_resp, 4'(delay)};
      end
      num_built++;
   endtask

   task automatic build_table();
      logic [31:0] seed;
      axil_data_t  led_a;
      axil_data_t  led_b;
      axil_data_t  tag;
      vdip_t       dip;
      vled_t       led;
      seed  = lcg_next(32'd72879);
      led_a = seed;
      seed  = lcg_next(seed);
      led_b = seed;
      seed  = lcg_next(seed);
      dip   = seed[23:8];
      seed  = lcg_next(seed);
      tag   = seed;
      led   = LED_INIT;
      add_test(OP_RD, REG_ID0, '0, '0, ID0, RESP_OKAY, 0);
      add_test(OP_RD, REG_ID1, '0, '0, ID1, RESP_OKAY, 2);
      add_test(OP_PORT, '0, '0, '0, led, RESP_OKAY, 0);
      add_test(OP_RD, REG_VLED, '0, '0, led, RESP_OKAY, 0);
      led = merge_vled(led, led_a, 4'b0001);
      add_test(OP_WR, REG_VLED, led_a, 4'b0001, '0, RESP_OKAY, 3);
      add_test(OP_PORT, '0, '0, '0, led, RESP_OKAY, 0);
      add_test(OP_RD, REG_VLED, '0, '0, led, RESP_OKAY, 4);
      // Upper strobes have no LED byte behind them
      led = merge_vled(led, led_b, 4'b1110);
      add_test(OP_WR, REG_VLED, led_b, 4'b1110, '0, RESP_OKAY, 1);
      add_test(OP_PORT, '0, '0, '0, led, RESP_OKAY, 0);
      add_test(OP_RD, REG_VLED, '0, '0, led, RESP_OKAY, 2);
      add_test(OP_DIP, '0, dip, '0, '0, RESP_OKAY, 0);
      add_test(OP_RD, REG_VDIP, '0, '0, dip, RESP_OKAY, 0);
      add_test(OP_CYC, REG_CYCLE, '0, '0, '0, RESP_OKAY, 1);
      add_test(OP_WR, REG_STAT, tag, 4'b0001, '0, RESP_OKAY, 2);
      add_test(OP_RD, REG_STAT, '0, '0, tag, RESP_OKAY, 0);
      add_test(OP_STATCYC, REG_STAT_CYCLE, '0, '0, '0, RESP_OKAY, 0);
      add_test(OP_RD, 32'h0000_001C, '0, '0, '0, RESP_SLVERR, 1);
      add_test(OP_RD, 32'h0000_0108, '0, '0, '0, RESP_SLVERR, 0);
      add_test(OP_WR, REG_VDIP, ~tag, 4'hF, '0, RESP_SLVERR, 2);
      add_test(OP_RD, REG_VDIP, '0, '0, dip, RESP_OKAY, 0);
      add_test(OP_RD, REG_VLED, '0, '0, led, RESP_OKAY, 0);
      add_test(OP_PORT, '0, '0, '0, led, RESP_OKAY, 0);
      add_test(OP_WR, REG_ID0, tag, 4'hF, '0, RESP_SLVERR, 0);
      add_test(OP_RD, REG_ID0, '0, '0, ID0, RESP_OKAY, 0);
   endtask

   initial begin : main
      test_t      t;
      axil_data_t rdata;
      axil_resp_t rresp;
      cycle_t     c0;
      int         pulses;
      int         err_before;
      s_axil_req = '0;
      vdip       = '0;
      build_table();
      if (num_built != NUM_TESTS) begin
         note_failure("stimulus table size does not match its declared length");
      end
      wait (rst_main_n_sync === 1'b1);
      @(negedge clk_main_a0);
      #(SETTLE_NS);
      for (int i = 0; i < NUM_TESTS; i++) begin
         t          = tests[i];
         err_before = err_cnt;
         case (t.op)
            OP_RD: begin
               axil_read(t.addr, t.delay, rdata, rresp);
               check_data(rdata, t.exp_data, "read data");
               check_resp(rresp, t.exp_resp, "read response");
            end
            OP_WR: begin
               pulses = pulse_cnt;
               axil_write(t.addr, t.wdata, t.strb, t.delay, rresp);
               check_resp(rresp, t.exp_resp, "write response");
               check_stat(pulse_cnt - pulses, (t.addr == REG_STAT) ? 1 : 0, pulse_tag, t.wdata);
            end
            OP_PORT: check_vled(vled_port, vled_t'(t.exp_data));
            OP_DIP: begin
               @(negedge clk_main_a0);
               vdip = vdip_t'(t.wdata);
               // Two synchronizer stages plus one cycle of margin
               repeat (3) @(negedge clk_main_a0);
               #(SETTLE_NS);
            end
            OP_CYC: begin
               axil_read(REG_CYCLE, t.delay, rdata, rresp);
               c0 = rdata;
               axil_read(REG_CYCLE, t.delay, rdata, rresp);
               check_resp(rresp, RESP_OKAY, "cycle read response");
               check_cycle_order(c0, rdata, 1'b1, "second cycle read");
            end
            default: begin
               axil_read(REG_STAT_CYCLE, t.delay, rdata, rresp);
               c0 = rdata;
               check_resp(rresp, RESP_OKAY, "stat cycle response");
               axil_read(REG_CYCLE, t.delay, rdata, rresp);
               check_cycle_order('0, c0, 1'b1, "stat cycle");
               check_cycle_order(c0, rdata, 1'b0, "cycle after stat");
            end
         endcase
         if (err_cnt != err_before) begin
            fail_cnt++;
         end
         $display("Test %0d %s addr %h: %s", i, t.op.name(), t.addr,
                  (err_cnt == err_before) ? "passed" : "FAILED");
      end
      $display("%0d of %0d tests failed, %0d errors", fail_cnt, NUM_TESTS, err_cnt);
      if (err_cnt == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

   // Budget of 50 cycles per table entry
   initial begin : watchdog
      repeat (NUM_TESTS * 50) @(posedge clk_main_a0);
      $display("Run stopped by the watchdog after %0d cycles", NUM_TESTS * 50);
      $display("Something failed");
      $finish;
   end

endmodule

//--- tb_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/10ps

module tb_clk_gen #(
   parameter int CLK_PERIOD = 10
) (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(CLK_PERIOD / 2) clk_o = ~clk_o;
   end

   // Reset spans two rising edges and is released on a falling edge
   initial begin
      rst_n_o = 1'b0;
      repeat (2) @(posedge clk_o);
      @(negedge clk_o);
      rst_n_o = 1'b1;
   end

endmodule

//--- cl_top.sv
// Custom logic shell top
`timescale 1ns/10ps

module cl_top #(
   parameter axil_pkg::axil_data_t CL_ID0      = 32'hF001_1D0F,
   parameter axil_pkg::axil_data_t CL_ID1      = 32'h1D51_FEDC,
   parameter cl_shell_pkg::vled_t  LED_PATTERN = 16'hBEEF
) (
   input  logic                 clk_main_a0,
   input  logic                 rst_main_n_sync,
   input  axil_pkg::axil_req_t  s_axil_req_i,
   output axil_pkg::axil_rsp_t  s_axil_rsp_o,
   input  cl_shell_pkg::vdip_t  sh_cl_status_vdip_i,
   output cl_shell_pkg::vled_t  cl_sh_status_vled_o,
   output logic                 print_stat_v_o,
   output axil_pkg::axil_data_t print_stat_tag_o
);
   import axil_pkg::*;
   import cl_shell_pkg::*;

   // Slice to register block
   axil_req_t    ctrl_req;
   axil_rsp_t    ctrl_rsp;

   // Register block to datapath
   vled_wr_t     vled_wr;
   vled_t        vled;
   vdip_t        vdip;
   stat_wr_t     stat_wr;
   prof_status_t prof;

   axil_reg_slice u_axil_reg_slice (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .s_req_i         (s_axil_req_i),
      .s_rsp_o         (s_axil_rsp_o),
      .m_req_o         (ctrl_req),
      .m_rsp_i         (ctrl_rsp)
   );

   cl_ctrl #(
      .CL_ID0 (CL_ID0),
      .CL_ID1 (CL_ID1)
   ) u_cl_ctrl (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .req_i           (ctrl_req),
      .rsp_o           (ctrl_rsp),
      .vled_wr_o       (vled_wr),
      .vled_i          (vled),
      .vdip_i          (vdip),
      .stat_wr_o       (stat_wr),
      .prof_i          (prof)
   );

   status_io #(
      .LED_PATTERN (LED_PATTERN)
   ) u_status_io (
      .clk_main_a0         (clk_main_a0),
      .rst_main_n_sync     (rst_main_n_sync),
      .vled_wr_i           (vled_wr),
      .vled_o              (vled),
      .cl_sh_status_vled_o (cl_sh_status_vled_o),
      .sh_cl_status_vdip_i (sh_cl_status_vdip_i),
      .vdip_o              (vdip)
   );

   profile_counter u_profile_counter (
      .clk_main_a0      (clk_main_a0),
      .rst_main_n_sync  (rst_main_n_sync),
      .stat_wr_i        (stat_wr),
      .prof_o           (prof),
      .print_stat_v_o   (print_stat_v_o),
      .print_stat_tag_o (print_stat_tag_o)
   );

endmodule

//--- profile_counter.sv
// Cycle counter and print-stat
`timescale 1ns/10ps

module profile_counter (
   input  logic                       clk_main_a0,
   input  logic                       rst_main_n_sync,
   input  cl_shell_pkg::stat_wr_t     stat_wr_i,
   output cl_shell_pkg::prof_status_t prof_o,
   output logic                       print_stat_v_o,
   output axil_pkg::axil_data_t       print_stat_tag_o
);
   import axil_pkg::*;
   import cl_shell_pkg::*;

   cycle_t     cycle_q;
   cycle_t     stat_cycle_q;
   axil_data_t stat_tag_q;
   logic       print_stat_v_q;

   // Free-running counter that wraps silently
   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
         cycle_q        <= '0;
         print_stat_v_q <= 1'b0;
      end else begin
         cycle_q        <= cycle_q + 1'b1;
         print_stat_v_q <= stat_wr_i.valid;
      end
   end

   // Tag and timestamp stay readable until the next stat write
   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
         stat_tag_q   <= '0;
         stat_cycle_q <= '0;
      end else if (stat_wr_i.valid) begin
         stat_tag_q   <= stat_wr_i.tag;
         stat_cycle_q <= cycle_q;
      end
   end

   assign prof_o.cycle      = cycle_q;
   assign prof_o.stat_tag   = stat_tag_q;
   assign prof_o.stat_cycle = stat_cycle_q;
   assign print_stat_v_o    = print_stat_v_q;
   assign print_stat_tag_o  = stat_tag_q;

endmodule

//--- status_io.sv
// Virtual LED and DIP switches
`timescale 1ns/10ps

module status_io #(
   parameter cl_shell_pkg::vled_t LED_PATTERN = 16'hBEEF
) (
   input  logic                   clk_main_a0,
   input  logic                   rst_main_n_sync,
   input  cl_shell_pkg::vled_wr_t vled_wr_i,
   output cl_shell_pkg::vled_t    vled_o,
   output cl_shell_pkg::vled_t    cl_sh_status_vled_o,
   input  cl_shell_pkg::vdip_t    sh_cl_status_vdip_i,
   output cl_shell_pkg::vdip_t    vdip_o
);
   import cl_shell_pkg::*;

   localparam int NUM_BYTES = $bits(vled_t) / 8;

   vled_t vled_q;
   vled_t vled_d;
   vled_t vled_out_q;
   vdip_t vdip_meta_q;
   vdip_t vdip_sync_q;

   // Byte merge of a host write
   always_comb begin
      vled_d = vled_q;
      if (vled_wr_i.valid) begin
         for (int b = 0; b < NUM_BYTES; b++) begin
            if (vled_wr_i.be[b]) begin
               vled_d[b*8 +: 8] = vled_wr_i.data[b*8 +: 8];
            end
         end
      end
   end

   // Output flop trails the LED register by one cycle
   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
         vled_q      <= LED_PATTERN;
         vled_out_q  <= '0;
         vdip_meta_q <= '0;
         vdip_sync_q <= '0;
      end else begin
         vled_q      <= vled_d;
         vled_out_q  <= vled_q;
         vdip_meta_q <= sh_cl_status_vdip_i;
         vdip_sync_q <= vdip_meta_q;
      end
   end

   assign vled_o              = vled_q;
   assign cl_sh_status_vled_o = vled_out_q;
   assign vdip_o              = vdip_sync_q;

endmodule

//--- cl_ctrl.sv
// Register block control
`timescale 1ns/10ps

module cl_ctrl #(
   parameter axil_pkg::axil_data_t CL_ID0 = 32'hF001_1D0F,
   parameter axil_pkg::axil_data_t CL_ID1 = 32'h1D51_FEDC
) (
   input  logic                       clk_main_a0,
   input  logic                       rst_main_n_sync,
   input  axil_pkg::axil_req_t        req_i,
   output axil_pkg::axil_rsp_t        rsp_o,
   output cl_shell_pkg::vled_wr_t     vled_wr_o,
   input  cl_shell_pkg::vled_t        vled_i,
   input  cl_shell_pkg::vdip_t        vdip_i,
   output cl_shell_pkg::stat_wr_t     stat_wr_o,
   input  cl_shell_pkg::prof_status_t prof_i
);
   import axil_pkg::*;
   import cl_shell_pkg::*;

   typedef enum logic {W_IDLE, W_RESP} wr_state_e;
   typedef enum logic {R_IDLE, R_RESP} rd_state_e;

   localparam int OFF_W = $bits(reg_off_t);

   wr_state_e  wr_state_q;
   rd_state_e  rd_state_q;
   logic       wr_accept;
   logic       rd_accept;
   reg_off_t   wr_off;
   reg_off_t   rd_off;
   axil_resp_t wr_resp;
   axil_resp_t rd_resp;
   axil_data_t rd_data;
   axil_resp_t b_resp_q;
   axil_resp_t r_resp_q;
   axil_data_t r_data_q;

   // Upper address bits must be clear to hit the window
   function automatic logic in_window(input axil_addr_t addr);
      return addr[$bits(axil_addr_t)-1:OFF_W] == '0;
   endfunction

   function automatic reg_off_t word_off(input axil_addr_t addr);
      return {addr[OFF_W-1:2], 2'b00};
   endfunction

   // ------------------------------
   // Write path
   // ------------------------------
   assign wr_accept = (wr_state_q == W_IDLE) && req_i.aw_valid && req_i.w_valid;
   assign wr_off    = word_off(req_i.aw_addr);

   always_comb begin
      wr_resp         = RESP_SLVERR;
      vled_wr_o.valid = 1'b0;
      vled_wr_o.data  = req_i.w_data[$bits(vled_t)-1:0];
      vled_wr_o.be    = req_i.w_strb[1:0];
      stat_wr_o.valid = 1'b0;
      // STAT ignores strobes and takes the full word
      stat_wr_o.tag   = req_i.w_data;
      if (in_window(req_i.aw_addr)) begin
         case (wr_off)
            REG_VLED: begin
               wr_resp         = RESP_OKAY;
               vled_wr_o.valid = wr_accept;
            end
            REG_STAT: begin
               wr_resp         = RESP_OKAY;
               stat_wr_o.valid = wr_accept;
            end
            default: begin
               wr_resp = RESP_SLVERR;
            end
         endcase
      end
   end

   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
         wr_state_q <= W_IDLE;
      end else if (wr_state_q == W_IDLE && wr_accept) begin
         wr_state_q <= W_RESP;
      end else if (wr_state_q == W_RESP && req_i.b_ready) begin
         wr_state_q <= W_IDLE;
      end
   end

   always_ff @(posedge clk_main_a0) begin
      if (wr_accept) begin
         b_resp_q <= wr_resp;
      end
   end

   // ------------------------------
   // Read path
   // ------------------------------
   assign rd_accept = (rd_state_q == R_IDLE) && req_i.ar_valid;
   assign rd_off    = word_off(req_i.ar_addr);

   always_comb begin
      rd_resp = RESP_OKAY;
      rd_data = '0;
      if (!in_window(req_i.ar_addr)) begin
         rd_resp = RESP_SLVERR;
      end else begin
         case (rd_off)
            REG_ID0:        rd_data = CL_ID0;
            REG_ID1:        rd_data = CL_ID1;
            REG_VLED:       rd_data = axil_data_t'(vled_i);
            REG_VDIP:       rd_data = axil_data_t'(vdip_i);
            REG_CYCLE:      rd_data = prof_i.cycle;
            REG_STAT:       rd_data = prof_i.stat_tag;
            REG_STAT_CYCLE: rd_data = prof_i.stat_cycle;
            default:        rd_resp = RESP_SLVERR;
         endcase
      end
   end

   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
         rd_state_q <= R_IDLE;
      end else if (rd_state_q == R_IDLE && rd_accept) begin
         rd_state_q <= R_RESP;
      end else if (rd_state_q == R_RESP && req_i.r_ready) begin
         rd_state_q <= R_IDLE;
      end
   end

   // Read data is sampled once and held while r_valid waits
   always_ff @(posedge clk_main_a0) begin
      if (rd_accept) begin
         r_data_q <= rd_data;
         r_resp_q <= rd_resp;
      end
   end

   always_comb begin
      rsp_o.aw_ready = wr_accept;
      rsp_o.w_ready  = wr_accept;
      rsp_o.b_resp   = b_resp_q;
      rsp_o.b_valid  = (wr_state_q == W_RESP);
      rsp_o.ar_ready = rd_accept;
      rsp_o.r_data   = r_data_q;
      rsp_o.r_resp   = r_resp_q;
      rsp_o.r_valid  = (rd_state_q == R_RESP);
   end

endmodule

//--- axil_reg_slice.sv
// AXI-Lite register slice
`timescale 1ns/10ps

module axil_reg_slice (
   input  logic                clk_main_a0,
   input  logic                rst_main_n_sync,
   input  axil_pkg::axil_req_t s_req_i,
   output axil_pkg::axil_rsp_t s_rsp_o,
   output axil_pkg::axil_req_t m_req_o,
   input  axil_pkg::axil_rsp_t m_rsp_i
);
   import axil_pkg::*;

   localparam int NUM_CH = 5;
   localparam int CH_AW  = 0;
   localparam int CH_W   = 1;
   localparam int CH_B   = 2;
   localparam int CH_AR  = 3;
   localparam int CH_R   = 4;

   localparam int ADDR_W = $bits(axil_addr_t);
   localparam int DATA_W = $bits(axil_data_t);
   localparam int STRB_W = $bits(axil_strb_t);
   localparam int RESP_W = $bits(axil_resp_t);
   // W is the widest channel so the others are zero padded
   localparam int PLD_W  = DATA_W + STRB_W;

   typedef logic [PLD_W-1:0] pld_t;

   pld_t [NUM_CH-1:0] in_pld;
   pld_t [NUM_CH-1:0] pld_q;
   logic [NUM_CH-1:0] in_valid;
   logic [NUM_CH-1:0] in_ready;
   logic [NUM_CH-1:0] out_ready;
   logic [NUM_CH-1:0] full_q;

   // ------------------------------
   // Channel packing
   // ------------------------------
   always_comb begin
      in_pld[CH_AW]    = pld_t'(s_req_i.aw_addr);
      in_pld[CH_W]     = pld_t'({s_req_i.w_strb, s_req_i.w_data});
      in_pld[CH_B]     = pld_t'(m_rsp_i.b_resp);
      in_pld[CH_AR]    = pld_t'(s_req_i.ar_addr);
      in_pld[CH_R]     = pld_t'({m_rsp_i.r_resp, m_rsp_i.r_data});

      in_valid[CH_AW]  = s_req_i.aw_valid;
      in_valid[CH_W]   = s_req_i.w_valid;
      in_valid[CH_B]   = m_rsp_i.b_valid;
      in_valid[CH_AR]  = s_req_i.ar_valid;
      in_valid[CH_R]   = m_rsp_i.r_valid;

      out_ready[CH_AW] = m_rsp_i.aw_ready;
      out_ready[CH_W]  = m_rsp_i.w_ready;
      out_ready[CH_B]  = s_req_i.b_ready;
      out_ready[CH_AR] = m_rsp_i.ar_ready;
      out_ready[CH_R]  = s_req_i.r_ready;
   end

   // Stage takes data when empty or drained this cycle
   always_comb begin
      for (int i = 0; i < NUM_CH; i++) begin
         in_ready[i] = in_valid[i] && (!full_q[i] || out_ready[i]);
      end
   end

   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
         full_q <= '0;
      end else begin
         for (int i = 0; i < NUM_CH; i++) begin
            if (!full_q[i] || out_ready[i]) begin
               full_q[i] <= in_valid[i];
            end
         end
      end
   end

   always_ff @(posedge clk_main_a0) begin
      for (int i = 0; i < NUM_CH; i++) begin
         if (in_ready[i]) begin
            pld_q[i] <= in_pld[i];
         end
      end
   end

   // ------------------------------
   // Channel unpacking
   // ------------------------------
   always_comb begin
      m_req_o.aw_addr  = pld_q[CH_AW][ADDR_W-1:0];
      m_req_o.aw_valid = full_q[CH_AW];
      m_req_o.w_data   = pld_q[CH_W][DATA_W-1:0];
      m_req_o.w_strb   = pld_q[CH_W][DATA_W +: STRB_W];
      m_req_o.w_valid  = full_q[CH_W];
      m_req_o.b_ready  = in_ready[CH_B];
      m_req_o.ar_addr  = pld_q[CH_AR][ADDR_W-1:0];
      m_req_o.ar_valid = full_q[CH_AR];
      m_req_o.r_ready  = in_ready[CH_R];

      s_rsp_o.aw_ready = in_ready[CH_AW];
      s_rsp_o.w_ready  = in_ready[CH_W];
      s_rsp_o.b_resp   = pld_q[CH_B][RESP_W-1:0];
      s_rsp_o.b_valid  = full_q[CH_B];
      s_rsp_o.ar_ready = in_ready[CH_AR];
      s_rsp_o.r_data   = pld_q[CH_R][DATA_W-1:0];
      s_rsp_o.r_resp   = pld_q[CH_R][DATA_W +: RESP_W];
      s_rsp_o.r_valid  = full_q[CH_R];
   end

endmodule

//--- cl_shell_pkg.sv
// Shell register map types
package cl_shell_pkg;

   typedef logic [15:0] vled_t;
   typedef logic [15:0] vdip_t;
   typedef logic [31:0] cycle_t;

   // Byte offset inside the register window
   typedef logic [7:0]  reg_off_t;

   // ------------------------------
   // Register map
   // ------------------------------
   localparam reg_off_t REG_ID0        = 8'h00;
   localparam reg_off_t REG_ID1        = 8'h04;
   localparam reg_off_t REG_VLED       = 8'h08;
   localparam reg_off_t REG_VDIP       = 8'h0C;
   localparam reg_off_t REG_CYCLE      = 8'h10;
   localparam reg_off_t REG_STAT       = 8'h14;
   localparam reg_off_t REG_STAT_CYCLE = 8'h18;

   // LED update, one enable per byte
   typedef struct packed {
      logic       valid;
      vled_t      data;
      logic [1:0] be;
   } vled_wr_t;

   // Print-stat request with its tag word
   typedef struct packed {
      logic                 valid;
      axil_pkg::axil_data_t tag;
   } stat_wr_t;

   // Profiling state seen by the read mux
   typedef struct packed {
      cycle_t               cycle;
      axil_pkg::axil_data_t stat_tag;
      cycle_t               stat_cycle;
   } prof_status_t;

endpackage

//--- axil_pkg.sv
// AXI-Lite bus types
package axil_pkg;

   // ------------------------------
   // Field widths
   // ------------------------------
   typedef logic [31:0] axil_addr_t;
   typedef logic [31:0] axil_data_t;
   typedef logic [3:0]  axil_strb_t;
   typedef logic [1:0]  axil_resp_t;

   // Response codes
   localparam axil_resp_t RESP_OKAY   = 2'b00;
   localparam axil_resp_t RESP_SLVERR = 2'b10;

   // Everything driven by the manager
   typedef struct packed {
      axil_addr_t aw_addr;
      logic       aw_valid;
      axil_data_t w_data;
      axil_strb_t w_strb;
      logic       w_valid;
      logic       b_ready;
      axil_addr_t ar_addr;
      logic       ar_valid;
      logic       r_ready;
   } axil_req_t;

   // Everything driven by the subordinate
   typedef struct packed {
      logic       aw_ready;
      logic       w_ready;
      axil_resp_t b_resp;
      logic       b_valid;
      logic       ar_ready;
      axil_data_t r_data;
      axil_resp_t r_resp;
      logic       r_valid;
   } axil_rsp_t;

endpackage
